// ==== rtl/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu (
  input  rv_isa_pkg::funct3_t i_funct3,
  input  logic                i_alt,
  input  rv_core_pkg::xlen_t  i_src1,
  input  rv_core_pkg::xlen_t  i_src2,
  output rv_core_pkg::xlen_t  o_result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = i_src2[4:0];
  assign lt_signed = ($signed(i_src1) < $signed(i_src2));
  assign lt_unsigned = (i_src1 < i_src2);

  always_comb begin
    case (i_funct3)
      rv_isa_pkg::FUNCT3_ADD: begin
        if (i_alt) begin
          o_result = i_src1 - i_src2;
        end else begin
          o_result = i_src1 + i_src2;
        end
      end
      rv_isa_pkg::FUNCT3_SLL:  o_result = i_src1 << shamt;
      rv_isa_pkg::FUNCT3_SLT:  o_result = {31'd0, lt_signed};
      rv_isa_pkg::FUNCT3_SLTU: o_result = {31'd0, lt_unsigned};
      rv_isa_pkg::FUNCT3_XOR:  o_result = i_src1 ^ i_src2;
      rv_isa_pkg::FUNCT3_SRL: begin
        // arithmetic shift keeps the sign bit
        if (i_alt) begin
          o_result = $signed(i_src1) >>> shamt;
        end else begin
          o_result = i_src1 >> shamt;
        end
      end
      rv_isa_pkg::FUNCT3_OR:   o_result = i_src1 | i_src2;
      rv_isa_pkg::FUNCT3_AND:  o_result = i_src1 & i_src2;
      default:                 o_result = '0;
    endcase
  end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/100ps

module rv_core #(
  parameter rv_core_pkg::pc_t RESET_PC = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  i_inst_valid,
  input  rv_isa_pkg::inst_t     i_inst,
  output logic                  o_ret_valid,
  output rv_isa_pkg::reg_addr_t o_ret_rd,
  output logic                  o_ret_we,
  output rv_core_pkg::xlen_t    o_ret_data,
  output rv_core_pkg::instret_t o_instret
);

  // decode bundle
  logic                  dec_valid;
  rv_core_pkg::pc_t      dec_pc;
  rv_core_pkg::xlen_t    dec_imm;
  rv_isa_pkg::reg_addr_t dec_rs1;
  rv_isa_pkg::reg_addr_t dec_rs2;
  rv_isa_pkg::reg_addr_t dec_rd;
  logic                  dec_we;
  rv_isa_pkg::funct3_t   dec_funct3;
  logic                  dec_alt;
  logic                  dec_src1_sel_pc;
  logic                  dec_src1_zero;
  logic                  dec_src2_imm;

  // register file read data
  rv_core_pkg::xlen_t    rf_rs1_data;
  rv_core_pkg::xlen_t    rf_rs2_data;

  // result bundle
  logic                  ex_valid;
  rv_isa_pkg::reg_addr_t ex_rd;
  logic                  ex_we;
  rv_core_pkg::xlen_t    ex_data;

  rv_decode #(
    .RESET_PC(RESET_PC)
  ) DECODE (
    .clk(clk),
    .nrst(nrst),
    .i_inst_valid(i_inst_valid),
    .i_inst(i_inst),
    .o_dec_valid(dec_valid),
    .o_dec_pc(dec_pc),
    .o_dec_imm(dec_imm),
    .o_dec_rs1(dec_rs1),
    .o_dec_rs2(dec_rs2),
    .o_dec_rd(dec_rd),
    .o_dec_we(dec_we),
    .o_dec_funct3(dec_funct3),
    .o_dec_alt(dec_alt),
    .o_dec_src1_pc(dec_src1_sel_pc),
    .o_dec_src1_zero(dec_src1_zero),
    .o_dec_src2_imm(dec_src2_imm)
  );

  rv_execute EXECUTE (
    .clk(clk),
    .nrst(nrst),
    .i_dec_valid(dec_valid),
    .i_dec_pc(dec_pc),
    .i_dec_imm(dec_imm),
    .i_dec_rs1(dec_rs1),
    .i_dec_rs2(dec_rs2),
    .i_dec_rd(dec_rd),
    .i_dec_we(dec_we),
    .i_dec_funct3(dec_funct3),
    .i_dec_alt(dec_alt),
    .i_dec_src1_pc(dec_src1_sel_pc),
    .i_dec_src1_zero(dec_src1_zero),
    .i_dec_src2_imm(dec_src2_imm),
    .i_rf_rs1_data(rf_rs1_data),
    .i_rf_rs2_data(rf_rs2_data),
    .o_ex_valid(ex_valid),
    .o_ex_rd(ex_rd),
    .o_ex_we(ex_we),
    .o_ex_data(ex_data)
  );

  rv_retire RETIRE (
    .clk(clk),
    .nrst(nrst),
    .i_rs1_addr(dec_rs1),
    .i_rs2_addr(dec_rs2),
    .i_ex_valid(ex_valid),
    .i_ex_rd(ex_rd),
    .i_ex_we(ex_we),
    .i_ex_data(ex_data),
    .o_rs1_data(rf_rs1_data),
    .o_rs2_data(rf_rs2_data),
    .o_ret_valid(o_ret_valid),
    .o_ret_rd(o_ret_rd),
    .o_ret_we(o_ret_we),
    .o_ret_data(o_ret_data),
    .o_instret(o_instret)
  );

endmodule

// ==== rtl/rv_core_pkg.sv ====
package rv_core_pkg;

  // data path widths
  localparam int XLEN = 32;
  localparam int INSTRET_W = 64;

  typedef logic [XLEN-1:0] xlen_t;

  typedef logic [XLEN-1:0] pc_t;

  // retired instruction count, same width as instret
  typedef logic [INSTRET_W-1:0] instret_t;

  // sequential instruction size in bytes
  localparam pc_t PC_STEP = 32'd4;

endpackage

// ==== rtl/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode #(
  parameter rv_core_pkg::pc_t RESET_PC = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  i_inst_valid,
  input  rv_isa_pkg::inst_t     i_inst,
  output logic                  o_dec_valid,
  output rv_core_pkg::pc_t      o_dec_pc,
  output rv_core_pkg::xlen_t    o_dec_imm,
  output rv_isa_pkg::reg_addr_t o_dec_rs1,
  output rv_isa_pkg::reg_addr_t o_dec_rs2,
  output rv_isa_pkg::reg_addr_t o_dec_rd,
  output logic                  o_dec_we,
  output rv_isa_pkg::funct3_t   o_dec_funct3,
  output logic                  o_dec_alt,
  output logic                  o_dec_src1_pc,
  output logic                  o_dec_src1_zero,
  output logic                  o_dec_src2_imm
);

  rv_core_pkg::pc_t      pc_q;
  rv_isa_pkg::opcode_t   opcode;
  rv_isa_pkg::funct3_t   funct3;
  rv_isa_pkg::reg_addr_t rd;
  logic                  is_op;
  logic                  is_op_imm;
  logic                  is_lui;
  logic                  is_auipc;
  rv_core_pkg::xlen_t    imm_d;
  logic                  we_d;
  rv_isa_pkg::funct3_t   funct3_d;
  logic                  alt_d;

  assign opcode = i_inst[6:2];
  assign funct3 = i_inst[14:12];
  assign rd = i_inst[11:7];

  assign is_op = (opcode == rv_isa_pkg::OPCODE_OP);
  assign is_op_imm = (opcode == rv_isa_pkg::OPCODE_OP_IMM);
  assign is_lui = (opcode == rv_isa_pkg::OPCODE_LUI);
  assign is_auipc = (opcode == rv_isa_pkg::OPCODE_AUIPC);

  always_comb begin
    // U-type for LUI/AUIPC, I-type otherwise
    if (is_lui || is_auipc) begin
      imm_d = {i_inst[31:12], 12'h000};
    end else begin
      imm_d = {{20{i_inst[31]}}, i_inst[31:20]};
    end

    // unsupported opcodes retire without a write
    we_d = (is_op || is_op_imm || is_lui || is_auipc) && (rd != '0);

    if (is_op || is_op_imm) begin
      funct3_d = funct3;
    end else begin
      funct3_d = rv_isa_pkg::FUNCT3_ADD;
    end

    // bit 30 is immediate data except for SRAI
    if (is_op) begin
      alt_d = i_inst[30];
    end else if (is_op_imm && funct3 == rv_isa_pkg::FUNCT3_SRL) begin
      alt_d = i_inst[30];
    end else begin
      alt_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (~nrst) begin
      pc_q <= RESET_PC;
      o_dec_valid <= 1'b0;
      o_dec_pc <= '0;
      o_dec_imm <= '0;
      o_dec_rs1 <= '0;
      o_dec_rs2 <= '0;
      o_dec_rd <= '0;
      o_dec_we <= 1'b0;
      o_dec_funct3 <= '0;
      o_dec_alt <= 1'b0;
      o_dec_src1_pc <= 1'b0;
      o_dec_src1_zero <= 1'b0;
      o_dec_src2_imm <= 1'b0;
    end else begin
      o_dec_valid <= i_inst_valid;
      if (i_inst_valid) begin
        pc_q <= pc_q + rv_core_pkg::PC_STEP;
        o_dec_pc <= pc_q;
        o_dec_imm <= imm_d;
        o_dec_rs1 <= i_inst[19:15];
        o_dec_rs2 <= i_inst[24:20];
        o_dec_rd <= rd;
        o_dec_we <= we_d;
        o_dec_funct3 <= funct3_d;
        o_dec_alt <= alt_d;
        o_dec_src1_pc <= is_auipc;
        o_dec_src1_zero <= is_lui;
        o_dec_src2_imm <= ~is_op;
      end
    end
  end

endmodule

// ==== rtl/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  i_dec_valid,
  input  rv_core_pkg::pc_t      i_dec_pc,
  input  rv_core_pkg::xlen_t    i_dec_imm,
  input  rv_isa_pkg::reg_addr_t i_dec_rs1,
  input  rv_isa_pkg::reg_addr_t i_dec_rs2,
  input  rv_isa_pkg::reg_addr_t i_dec_rd,
  input  logic                  i_dec_we,
  input  rv_isa_pkg::funct3_t   i_dec_funct3,
  input  logic                  i_dec_alt,
  input  logic                  i_dec_src1_pc,
  input  logic                  i_dec_src1_zero,
  input  logic                  i_dec_src2_imm,
  input  rv_core_pkg::xlen_t    i_rf_rs1_data,
  input  rv_core_pkg::xlen_t    i_rf_rs2_data,
  output logic                  o_ex_valid,
  output rv_isa_pkg::reg_addr_t o_ex_rd,
  output logic                  o_ex_we,
  output rv_core_pkg::xlen_t    o_ex_data
);

  logic               fwd_rs1;
  logic               fwd_rs2;
  rv_core_pkg::xlen_t rs1_val;
  rv_core_pkg::xlen_t rs2_val;
  rv_core_pkg::xlen_t src1;
  rv_core_pkg::xlen_t src2;
  rv_core_pkg::xlen_t alu_result;

  // previous instruction has not reached the register file yet
  assign fwd_rs1 = o_ex_valid && o_ex_we && (o_ex_rd == i_dec_rs1);
  assign fwd_rs2 = o_ex_valid && o_ex_we && (o_ex_rd == i_dec_rs2);

  assign rs1_val = fwd_rs1 ? o_ex_data : i_rf_rs1_data;
  assign rs2_val = fwd_rs2 ? o_ex_data : i_rf_rs2_data;

  always_comb begin
    if (i_dec_src1_zero) begin
      src1 = '0;
    end else if (i_dec_src1_pc) begin
      src1 = i_dec_pc;
    end else begin
      src1 = rs1_val;
    end
  end

  assign src2 = i_dec_src2_imm ? i_dec_imm : rs2_val;

  rv_alu ALU (
    .i_funct3(i_dec_funct3),
    .i_alt(i_dec_alt),
    .i_src1(src1),
    .i_src2(src2),
    .o_result(alu_result)
  );

  always_ff @(posedge clk) begin
    if (~nrst) begin
      o_ex_valid <= 1'b0;
      o_ex_rd <= '0;
      o_ex_we <= 1'b0;
      o_ex_data <= '0;
    end else begin
      o_ex_valid <= i_dec_valid;
      o_ex_rd <= i_dec_rd;
      // decode payload is stale without a strobe
      o_ex_we <= i_dec_valid & i_dec_we;
      o_ex_data <= alu_result;
    end
  end

endmodule

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // instruction word and field widths
  localparam int ILEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  typedef logic [ILEN-1:0] inst_t;

  // opcode without the two low bits
  typedef logic [4:0] opcode_t;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [2:0] funct3_t;

  // kept opcodes, inst[6:2]
  localparam opcode_t OPCODE_OP_IMM = 5'b00100;
  localparam opcode_t OPCODE_AUIPC = 5'b00101;
  localparam opcode_t OPCODE_OP = 5'b01100;
  localparam opcode_t OPCODE_LUI = 5'b01101;

  // integer operation codes, shared by OP and OP_IMM
  localparam funct3_t FUNCT3_ADD = 3'b000;
  localparam funct3_t FUNCT3_SLL = 3'b001;
  localparam funct3_t FUNCT3_SLT = 3'b010;
  localparam funct3_t FUNCT3_SLTU = 3'b011;
  localparam funct3_t FUNCT3_XOR = 3'b100;
  // SRA when inst[30] is set
  localparam funct3_t FUNCT3_SRL = 3'b101;
  localparam funct3_t FUNCT3_OR = 3'b110;
  localparam funct3_t FUNCT3_AND = 3'b111;

endpackage

// ==== rtl/rv_retire.sv ====
`timescale 1ns/100ps

module rv_retire (
  input  logic                  clk,
  input  logic                  nrst,
  input  rv_isa_pkg::reg_addr_t i_rs1_addr,
  input  rv_isa_pkg::reg_addr_t i_rs2_addr,
  input  logic                  i_ex_valid,
  input  rv_isa_pkg::reg_addr_t i_ex_rd,
  input  logic                  i_ex_we,
  input  rv_core_pkg::xlen_t    i_ex_data,
  output rv_core_pkg::xlen_t    o_rs1_data,
  output rv_core_pkg::xlen_t    o_rs2_data,
  output logic                  o_ret_valid,
  output rv_isa_pkg::reg_addr_t o_ret_rd,
  output logic                  o_ret_we,
  output rv_core_pkg::xlen_t    o_ret_data,
  output rv_core_pkg::instret_t o_instret
);

  rv_core_pkg::xlen_t rf [rv_isa_pkg::NUM_REGS];
  logic               rf_we;

  assign rf_we = i_ex_valid && i_ex_we && (i_ex_rd != '0);

  // x0 is hardwired to zero
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : rf[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : rf[i_rs2_addr];

  always_ff @(posedge clk) begin
    if (~nrst) begin
      rf <= '{default: '0};
    end else if (rf_we) begin
      rf[i_ex_rd] <= i_ex_data;
    end
  end

  // retire report, one per executed instruction
  always_ff @(posedge clk) begin
    if (~nrst) begin
      o_ret_valid <= 1'b0;
      o_ret_rd <= '0;
      o_ret_we <= 1'b0;
      o_ret_data <= '0;
    end else begin
      o_ret_valid <= i_ex_valid;
      o_ret_rd <= i_ex_rd;
      o_ret_we <= rf_we;
      o_ret_data <= i_ex_data;
    end
  end

  always_ff @(posedge clk) begin
    if (~nrst) begin
      o_instret <= '0;
    end else if (i_ex_valid) begin
      o_instret <= o_instret + rv_core_pkg::instret_t'(1);
    end
  end

endmodule

// ==== sim/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

logic [31:0] lcg_state = 32'd18;

// return the upper half since the low bits of an lcg repeat too soon
function automatic logic [15:0] next_random();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[31:16];
endfunction

function automatic rv_isa_pkg::inst_t r_type_word(input logic [6:0] funct7,
    input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
  return {funct7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic rv_isa_pkg::inst_t i_type_word(input logic [11:0] imm,
    input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic rv_isa_pkg::inst_t u_type_word(input logic [6:0] opcode,
    input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, opcode};
endfunction

// load encoding that this core does not handle
function automatic rv_isa_pkg::inst_t unsupported_word(input logic [11:0] imm,
    input logic [4:0] rs1, input logic [4:0] rd);
  return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

// returns {write flag, value}
function automatic logic [32:0] expected_result(input rv_isa_pkg::inst_t inst,
    input rv_core_pkg::pc_t pc, input rv_core_pkg::xlen_t regs [32]);
  logic [6:0]  opc;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic        writes;
  opc = inst[6:0];
  a = regs[inst[19:15]];
  b = (opc == 7'b0110011) ? regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
  writes = 1'b1;
  res = '0;
  case (opc)
    7'b0110111: res = {inst[31:12], 12'h000};
    7'b0010111: res = pc + {inst[31:12], 12'h000};
    7'b0010011, 7'b0110011: begin
      case (inst[14:12])
        3'd0: res = (opc == 7'b0110011 && inst[30]) ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: res = (a < b) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        3'd5: begin
          if (inst[30]) res = $signed(a) >>> b[4:0];
          else res = a >> b[4:0];
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
    end
    default: writes = 1'b0;
  endcase
  if (inst[11:7] == 5'd0) writes = 1'b0;
  return {writes, res};
endfunction

`endif

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

  localparam int NUM_INSTS = 300;
  localparam rv_core_pkg::pc_t RESET_PC = 32'h0000_1000;

  typedef struct packed {
    logic [31:0]           due;
    rv_isa_pkg::reg_addr_t rd;
    logic                  we;
    rv_core_pkg::xlen_t    data;
  } retire_t;

  logic                  clk;
  logic                  nrst;
  logic                  i_inst_valid;
  rv_isa_pkg::inst_t     i_inst;
  logic                  o_ret_valid;
  rv_isa_pkg::reg_addr_t o_ret_rd;
  logic                  o_ret_we;
  rv_core_pkg::xlen_t    o_ret_data;
  rv_core_pkg::instret_t o_instret;

  logic [31:0]           edge_count = '0;
  rv_core_pkg::xlen_t    model_regs [32] = '{default: '0};
  rv_core_pkg::pc_t      model_pc = RESET_PC;
  retire_t               pending_q [$];
  retire_t               got_entry;
  rv_core_pkg::instret_t retired_count = '0;
  int                    error_count = 0;

  rv_core #(.RESET_PC(RESET_PC)) UUT (
    .clk(clk), .nrst(nrst), .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .o_ret_valid(o_ret_valid), .o_ret_rd(o_ret_rd), .o_ret_we(o_ret_we),
    .o_ret_data(o_ret_data), .o_instret(o_instret)
  );

  `include "tb_rv_model.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) edge_count <= edge_count + 1;

  task automatic end_with_errors();
    error_count = error_count + 1;
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
      input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s got 0x%0h expected 0x%0h at edge %0d", name, actual, expected,
        edge_count);
      end_with_errors();
    end
  endtask

  function automatic rv_isa_pkg::inst_t random_instruction(input logic [4:0] prev_rd);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  funct7;
    rd = 5'(next_random());
    rs1 = next_random() % 2 ? prev_rd : 5'(next_random());
    rs2 = next_random() % 4 == 0 ? prev_rd : 5'(next_random());
    f3 = 3'(next_random());
    imm = 12'(next_random());
    // edges of the signed and unsigned compare range
    case (next_random() % 16)
      0: imm = 12'h7ff;
      1: imm = 12'h800;
      2: imm = 12'hfff;
      3: imm = 12'h000;
      default: ;
    endcase
    if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
    if (f3 == 3'd5) imm = {1'b0, 1'(next_random()), 5'd0, imm[4:0]};
    funct7 = ((f3 == 3'd0 || f3 == 3'd5) && next_random() % 2) ? 7'b0100000 : 7'd0;
    case (next_random() % 16)
      5, 6, 7, 8, 9: return r_type_word(funct7, rs2, rs1, f3, rd);
      10, 11: return u_type_word(7'b0110111, 20'({next_random(), next_random()}), rd);
      12: return u_type_word(7'b0010111, 20'({next_random(), next_random()}), rd);
      13: return unsupported_word(imm, rs1, rd);
      14: return i_type_word(imm, rs1, f3, 5'd0);
      default: return i_type_word(imm, rs1, f3, rd);
    endcase
  endfunction

  initial begin
    int                n;
    int                gap;
    rv_isa_pkg::inst_t inst;
    logic [32:0]       ref_out;
    retire_t           entry;
    logic [4:0]        prev_rd;
    nrst = 1'b0;
    i_inst_valid = 1'b0;
    i_inst = '0;
    prev_rd = '0;
    repeat (3) @(posedge clk);
    nrst <= 1'b1;
    for (n = 0; n < NUM_INSTS; n++) begin
      @(posedge clk);
      inst = random_instruction(prev_rd);
      ref_out = expected_result(inst, model_pc, model_regs);
      // edge_count lags this edge by one so the sampling edge is edge_count plus two
      entry.due = edge_count + 4;
      entry.rd = inst[11:7];
      entry.we = ref_out[32];
      entry.data = ref_out[31:0];
      pending_q.push_back(entry);
      if (ref_out[32]) model_regs[inst[11:7]] = ref_out[31:0];
      model_pc = model_pc + 32'd4;
      prev_rd = inst[11:7];
      i_inst_valid <= 1'b1;
      i_inst <= inst;
      gap = next_random() % 3;
      repeat (gap) begin
        @(posedge clk);
        i_inst_valid <= 1'b0;
      end
    end
    @(posedge clk);
    i_inst_valid <= 1'b0;
    while (pending_q.size() != 0) @(negedge clk);
    @(negedge clk);
    check_value("o_instret", o_instret, NUM_INSTS);
    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      end_with_errors();
    end
  end

  // outputs are settled mid cycle
  always @(negedge clk) begin
    if (nrst === 1'b1) begin
      if (o_ret_valid !== 1'b0) begin
        if (pending_q.size() == 0 || pending_q[0].due != edge_count) begin
          $display("a retire appeared at edge %0d with no instruction due", edge_count);
          end_with_errors();
        end else begin
          got_entry = pending_q.pop_front();
          retired_count = retired_count + 1;
          check_value("o_ret_rd", o_ret_rd, got_entry.rd);
          check_value("o_ret_we", o_ret_we, got_entry.we);
          if (got_entry.we) check_value("o_ret_data", o_ret_data, got_entry.data);
        end
      end else if (pending_q.size() != 0 && pending_q[0].due <= edge_count) begin
        $display("an instruction due at edge %0d did not retire", pending_q[0].due);
        end_with_errors();
      end
      check_value("o_instret", o_instret, retired_count);
    end
  end

  initial begin
    repeat (NUM_INSTS * 3 + 20) @(posedge clk);
    $display("timeout, the run did not finish in %0d cycles", NUM_INSTS * 3 + 20);
    end_with_errors();
  end

endmodule

// ==== tb.f ====
+incdir+sim
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_alu.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_retire.sv
rtl/rv_core.sv
sim/tb_rv_core.sv
